//--- src/mempool_lite_pkg.sv
/*
 * Shared widths, address map and boot image of the memory subsystem.
 * Window sizes are powers of two; the boot ROM window is exactly the image size.
 */
package mempool_lite_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // One wake-up bit per core
  localparam int unsigned NumCores = 8;
  typedef logic [NumCores-1:0] core_mask_t;

  // L2 geometry, word interleaved over the banks
  localparam int unsigned NumL2Banks     = 4;
  localparam int unsigned L2BankNumWords = 256;
  localparam int unsigned L2Size         = NumL2Banks * L2BankNumWords * StrbWidth;
  localparam addr_t       L2BaseAddr     = 32'h8000_0000;

  typedef logic [$clog2(NumL2Banks)-1:0]     l2_bank_idx_t;  // Address bits 3:2
  typedef logic [$clog2(L2BankNumWords)-1:0] l2_row_t;       // Address bits 11:4

  // Boot ROM
  localparam addr_t       BootromBaseAddr = 32'hA000_0000;
  localparam int unsigned BootromNumWords = 64;
  localparam int unsigned BootromSize     = BootromNumWords * StrbWidth;

  localparam data_t BootImage [BootromNumWords] = '{
    32'h0000_0297, 32'h0202_8293, 32'hF140_2573, 32'h0005_2583,
    32'h0000_0613, 32'h0010_0693, 32'h00B6_0733, 32'h0017_0713,
    32'h0040_0793, 32'h00F7_5463, 32'hFE1F_F06F, 32'h1050_0073,
    32'h3040_0073, 32'h3000_2073, 32'h0080_0093, 32'h4000_0137,
    32'h0011_2023, 32'h0041_2183, 32'h0081_2203, 32'h00C1_2283,
    32'h0000_8067, 32'h8000_0337, 32'h0003_2383, 32'h0043_2403,
    32'h0083_2483, 32'h00C3_2503, 32'h0103_2583, 32'h0143_2603,
    32'h0183_2683, 32'h01C3_2703, 32'hA000_07B7, 32'h0007_A803,
    32'h0047_A883, 32'h0087_A903, 32'h00C7_A983, 32'h0107_AA03,
    32'h0147_AA83, 32'h0187_AB03, 32'h01C7_AB83, 32'h0207_AC03,
    32'h0247_AC83, 32'h0287_AD03, 32'h02C7_AD83, 32'h0307_AE03,
    32'h0347_AE83, 32'h0387_AF03, 32'h03C7_AF83, 32'hDEAD_BEEF,
    32'hCAFE_F00D, 32'h1234_5678, 32'h9ABC_DEF0, 32'h0F1E_2D3C,
    32'h4B5A_6978, 32'h8796_A5B4, 32'hC3D2_E1F0, 32'h0102_0408,
    32'h1020_4080, 32'h5555_AAAA, 32'hAAAA_5555, 32'h3333_CCCC,
    32'hCCCC_3333, 32'h7F7F_7F7F, 32'h8080_8080, 32'hB007_0000
  };

  // Control-register window
  localparam addr_t       CtrlBaseAddr = 32'h4000_0000;
  localparam int unsigned CtrlSize     = 32'h0001_0000;

  // Word offsets inside the control window, address bits 3:2
  typedef enum logic [1:0] {
    RegEoc      = 2'd0,  // 0x0, read/write
    RegWakeUp   = 2'd1,  // 0x4, write-only
    RegNumCores = 2'd2,  // 0x8, read-only
    RegL2Size   = 2'd3   // 0xC, read-only
  } ctrl_reg_e;

  typedef enum logic [1:0] {
    TgtL2,
    TgtBootrom,
    TgtCtrl,
    TgtNone
  } target_e;

  typedef enum logic [1:0] {
    RespOkay   = 2'b00,
    RespSlvErr = 2'b10
  } axi_resp_e;

endpackage : mempool_lite_pkg

//--- src/axi_lite_frontend.sv
/*
 * AXI4-Lite slave, one transaction at a time; writes win over a read in the same cycle.
 * Unmapped addresses and boot ROM writes get SLVERR with read data 0.
 */
`timescale 1ns/1ns

module axi_lite_frontend (
  input  logic                          clk_i,
  input  logic                          reset_i,
  // Host write channels
  input  mempool_lite_pkg::addr_t       s_awaddr_i,
  input  logic                          s_awvalid_i,
  output logic                          s_awready_o,
  input  mempool_lite_pkg::data_t       s_wdata_i,
  input  mempool_lite_pkg::strb_t       s_wstrb_i,
  input  logic                          s_wvalid_i,
  output logic                          s_wready_o,
  output mempool_lite_pkg::axi_resp_e   s_bresp_o,
  output logic                          s_bvalid_o,
  input  logic                          s_bready_i,
  // Host read channels
  input  mempool_lite_pkg::addr_t       s_araddr_i,
  input  logic                          s_arvalid_i,
  output logic                          s_arready_o,
  output mempool_lite_pkg::data_t       s_rdata_o,
  output mempool_lite_pkg::axi_resp_e   s_rresp_o,
  output logic                          s_rvalid_o,
  input  logic                          s_rready_i,
  // Target side
  output logic                          l2_req_o,
  output logic                          rom_req_o,
  output logic                          reg_req_o,
  output logic                          mem_we_o,
  output mempool_lite_pkg::addr_t       mem_addr_o,
  output mempool_lite_pkg::data_t       mem_wdata_o,
  output mempool_lite_pkg::strb_t       mem_strb_o,
  input  mempool_lite_pkg::data_t       l2_rdata_i,
  input  mempool_lite_pkg::data_t       rom_rdata_i,
  input  mempool_lite_pkg::data_t       reg_rdata_i,
  output logic                          busy_o
);

  import mempool_lite_pkg::*;

  typedef enum logic [1:0] {
    FeIdle,
    FeAccess,  // Strobe cycle, then the cycle the target answers
    FeResp
  } fe_state_e;

  fe_state_e state_q, state_d;
  logic      req_q;       // High in the strobe cycle only
  logic      we_q;
  target_e   target_q;
  addr_t     addr_q;
  data_t     wdata_q;
  strb_t     strb_q;
  data_t     rdata_q;
  axi_resp_e resp_q;
  logic      take_write;
  logic      take_read;
  logic      access_err;
  logic      resp_done;
  data_t     sel_rdata;

  // Address map lookup, offsets compared against window sizes
  function automatic target_e decode_target(addr_t addr);
    target_e tgt;
    tgt = TgtNone;
    if ((addr - L2BaseAddr) < addr_t'(L2Size)) tgt = TgtL2;
    else if ((addr - BootromBaseAddr) < addr_t'(BootromSize)) tgt = TgtBootrom;
    else if ((addr - CtrlBaseAddr) < addr_t'(CtrlSize)) tgt = TgtCtrl;
    return tgt;
  endfunction

  // AW and W are only taken together
  assign take_write  = (state_q == FeIdle) && s_awvalid_i && s_wvalid_i;
  assign take_read   = (state_q == FeIdle) && s_arvalid_i && !take_write;
  assign s_awready_o = take_write;
  assign s_wready_o  = take_write;
  assign s_arready_o = take_read;

  assign resp_done  = (state_q == FeResp) && (we_q ? s_bready_i : s_rready_i);
  assign access_err = (target_q == TgtNone) || ((target_q == TgtBootrom) && we_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      FeIdle:   if (take_write || take_read) state_d = FeAccess;
      FeAccess: if (!req_q) state_d = FeResp;  // Target data is valid now
      FeResp:   if (resp_done) state_d = FeIdle;
      default:  state_d = FeIdle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= FeIdle;
      req_q   <= 1'b0;
      we_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      req_q   <= take_write || take_read;
      if (take_write || take_read) we_q <= take_write;
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if (take_write) begin
      target_q <= decode_target(s_awaddr_i);
      addr_q   <= s_awaddr_i;
      wdata_q  <= s_wdata_i;
      strb_q   <= s_wstrb_i;
    end else if (take_read) begin
      target_q <= decode_target(s_araddr_i);
      addr_q   <= s_araddr_i;
      wdata_q  <= '0;
      strb_q   <= '0;
    end
  end

  always_comb begin
    sel_rdata = '0;
    if (!we_q && !access_err) begin
      case (target_q)
        TgtL2:      sel_rdata = l2_rdata_i;
        TgtBootrom: sel_rdata = rom_rdata_i;
        TgtCtrl:    sel_rdata = reg_rdata_i;
        default:    sel_rdata = '0;
      endcase
    end
  end

  // Response is captured once and held until the host takes it
  always_ff @(posedge clk_i) begin
    if ((state_q == FeAccess) && !req_q) begin
      rdata_q <= sel_rdata;
      resp_q  <= access_err ? RespSlvErr : RespOkay;
    end
  end

  // One strobe per target, never on an error
  assign l2_req_o  = req_q && (target_q == TgtL2);
  assign rom_req_o = req_q && (target_q == TgtBootrom) && !we_q;
  assign reg_req_o = req_q && (target_q == TgtCtrl);

  assign mem_we_o    = we_q;
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = wdata_q;
  assign mem_strb_o  = strb_q;

  assign s_bvalid_o = (state_q == FeResp) && we_q;
  assign s_bresp_o  = resp_q;
  assign s_rvalid_o = (state_q == FeResp) && !we_q;
  assign s_rresp_o  = resp_q;
  assign s_rdata_o  = rdata_q;

  assign busy_o = (state_q != FeIdle);

endmodule : axi_lite_frontend

//--- src/l2_banks.sv
/*
 * Word-interleaved L2: bank from address bits 3:2, row from bits 11:4.
 * Read data is valid the cycle after the request and holds until the next read.
 */
`timescale 1ns/1ns

module l2_banks (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_i,
  input  logic                    we_i,
  input  mempool_lite_pkg::addr_t addr_i,
  input  mempool_lite_pkg::data_t wdata_i,
  input  mempool_lite_pkg::strb_t strb_i,
  output mempool_lite_pkg::data_t rdata_o
);

  import mempool_lite_pkg::*;

  l2_bank_idx_t          bank_idx;
  l2_bank_idx_t          bank_idx_q;  // Bank that answers the pending read
  l2_row_t               row;
  logic [NumL2Banks-1:0] bank_req;
  data_t                 bank_rdata [NumL2Banks];

  assign bank_idx = addr_i[3:2];
  assign row      = addr_i[11:4];

  for (genvar b = 0; b < NumL2Banks; b++) begin : gen_bank
    data_t mem_q [L2BankNumWords];
    data_t rdata_q;

    assign bank_req[b] = req_i && (bank_idx == l2_bank_idx_t'(b));

    always_ff @(posedge clk_i) begin
      if (bank_req[b]) begin
        if (we_i) begin
          for (int unsigned i = 0; i < StrbWidth; i++) begin
            if (strb_i[i]) mem_q[row][8*i +: 8] <= wdata_i[8*i +: 8];  // Byte lanes
          end
        end else begin
          rdata_q <= mem_q[row];
        end
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bank_idx_q <= '0;
    end else if (req_i && !we_i) begin
      bank_idx_q <= bank_idx;
    end
  end

  assign rdata_o = bank_rdata[bank_idx_q];

endmodule : l2_banks

//--- src/bootrom.sv
/* Read-only boot image, word index from address bits 7:2, one-cycle read latency */
`timescale 1ns/1ns

module bootrom (
  input  logic                    clk_i,
  input  logic                    req_i,
  input  mempool_lite_pkg::addr_t addr_i,
  output mempool_lite_pkg::data_t rdata_o
);

  import mempool_lite_pkg::*;

  logic [$clog2(BootromNumWords)-1:0] word_idx;
  data_t                              rdata_q;

  assign word_idx = addr_i[7:2];

  // Output register only moves on a request
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= BootImage[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule : bootrom

//--- src/ctrl_registers.sv
/*
 * Control registers at word offsets 0x0-0xC, aliased across the control window.
 * Wake-up takes the low NumCores data bits regardless of strobes.
 */
`timescale 1ns/1ns

module ctrl_registers (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  mempool_lite_pkg::addr_t      addr_i,
  input  mempool_lite_pkg::data_t      wdata_i,
  input  mempool_lite_pkg::strb_t      strb_i,
  output mempool_lite_pkg::data_t      rdata_o,
  output logic                         eoc_valid_o,
  output mempool_lite_pkg::core_mask_t wake_up_o
);

  import mempool_lite_pkg::*;

  ctrl_reg_e  reg_sel;
  logic       wr_en;
  logic       rd_en;
  data_t      eoc_q;
  core_mask_t wake_up_q;
  data_t      rdata_q;

  assign reg_sel = ctrl_reg_e'(addr_i[3:2]);
  assign wr_en   = req_i && we_i;
  assign rd_en   = req_i && !we_i;

  // End of computation, bit 0 is the flag
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      eoc_q <= '0;
    end else if (wr_en && (reg_sel == RegEoc)) begin
      for (int unsigned i = 0; i < StrbWidth; i++) begin
        if (strb_i[i]) eoc_q[8*i +: 8] <= wdata_i[8*i +: 8];
      end
    end
  end

  // Single-cycle wake-up pulse after the write
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wake_up_q <= '0;
    end else if (wr_en && (reg_sel == RegWakeUp)) begin
      wake_up_q <= wdata_i[NumCores-1:0];
    end else begin
      wake_up_q <= '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      case (reg_sel)
        RegEoc:      rdata_q <= eoc_q;
        RegWakeUp:   rdata_q <= '0;  // Write-only
        RegNumCores: rdata_q <= data_t'(NumCores);
        RegL2Size:   rdata_q <= data_t'(L2Size);
        default:     rdata_q <= '0;
      endcase
    end
  end

  assign rdata_o     = rdata_q;
  assign eoc_valid_o = eoc_q[0];
  assign wake_up_o   = wake_up_q;

endmodule : ctrl_registers

//--- src/mempool_lite_system.sv
/*
 * Memory subsystem top: AXI4-Lite front end routed to L2, boot ROM and control registers.
 * Only one host transaction is in flight at a time.
 */
`timescale 1ns/1ns

module mempool_lite_system (
  input  logic                         clk_i,
  input  logic                         reset_i,
  // Host AXI4-Lite slave
  input  mempool_lite_pkg::addr_t      s_awaddr_i,
  input  logic                         s_awvalid_i,
  output logic                         s_awready_o,
  input  mempool_lite_pkg::data_t      s_wdata_i,
  input  mempool_lite_pkg::strb_t      s_wstrb_i,
  input  logic                         s_wvalid_i,
  output logic                         s_wready_o,
  output mempool_lite_pkg::axi_resp_e  s_bresp_o,
  output logic                         s_bvalid_o,
  input  logic                         s_bready_i,
  input  mempool_lite_pkg::addr_t      s_araddr_i,
  input  logic                         s_arvalid_i,
  output logic                         s_arready_o,
  output mempool_lite_pkg::data_t      s_rdata_o,
  output mempool_lite_pkg::axi_resp_e  s_rresp_o,
  output logic                         s_rvalid_o,
  input  logic                         s_rready_i,
  // System status
  output logic                         eoc_valid_o,
  output mempool_lite_pkg::core_mask_t wake_up_o,
  output logic                         busy_o
);

  import mempool_lite_pkg::*;

  logic  l2_req;
  logic  rom_req;
  logic  reg_req;
  logic  mem_we;
  addr_t mem_addr;
  data_t mem_wdata;
  strb_t mem_strb;
  data_t l2_rdata;
  data_t rom_rdata;
  data_t reg_rdata;

  axi_lite_frontend i_axi_lite_frontend (
    .clk_i      (clk_i      ),
    .reset_i    (reset_i    ),
    .s_awaddr_i (s_awaddr_i ),
    .s_awvalid_i(s_awvalid_i),
    .s_awready_o(s_awready_o),
    .s_wdata_i  (s_wdata_i  ),
    .s_wstrb_i  (s_wstrb_i  ),
    .s_wvalid_i (s_wvalid_i ),
    .s_wready_o (s_wready_o ),
    .s_bresp_o  (s_bresp_o  ),
    .s_bvalid_o (s_bvalid_o ),
    .s_bready_i (s_bready_i ),
    .s_araddr_i (s_araddr_i ),
    .s_arvalid_i(s_arvalid_i),
    .s_arready_o(s_arready_o),
    .s_rdata_o  (s_rdata_o  ),
    .s_rresp_o  (s_rresp_o  ),
    .s_rvalid_o (s_rvalid_o ),
    .s_rready_i (s_rready_i ),
    .l2_req_o   (l2_req     ),
    .rom_req_o  (rom_req    ),
    .reg_req_o  (reg_req    ),
    .mem_we_o   (mem_we     ),
    .mem_addr_o (mem_addr   ),
    .mem_wdata_o(mem_wdata  ),
    .mem_strb_o (mem_strb   ),
    .l2_rdata_i (l2_rdata   ),
    .rom_rdata_i(rom_rdata  ),
    .reg_rdata_i(reg_rdata  ),
    .busy_o     (busy_o     )
  );

  l2_banks i_l2_banks (
    .clk_i  (clk_i    ),
    .reset_i(reset_i  ),
    .req_i  (l2_req   ),
    .we_i   (mem_we   ),
    .addr_i (mem_addr ),
    .wdata_i(mem_wdata),
    .strb_i (mem_strb ),
    .rdata_o(l2_rdata )
  );

  bootrom i_bootrom (
    .clk_i  (clk_i    ),
    .req_i  (rom_req  ),
    .addr_i (mem_addr ),
    .rdata_o(rom_rdata)
  );

  ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i      ),
    .reset_i    (reset_i    ),
    .req_i      (reg_req    ),
    .we_i       (mem_we     ),
    .addr_i     (mem_addr   ),
    .wdata_i    (mem_wdata  ),
    .strb_i     (mem_strb   ),
    .rdata_o    (reg_rdata  ),
    .eoc_valid_o(eoc_valid_o),
    .wake_up_o  (wake_up_o  )
  );

endmodule : mempool_lite_system

//--- testbench/tb_mempool_lite_system.sv
/*
 * Testbench for the memory subsystem covering L2, boot ROM, unmapped and control-register accesses.
 * Inputs change on the falling edge. The L2 checks only touch a pool of 32 words.
 */
`timescale 1ns/1ns

module tb_mempool_lite_system;

  import mempool_lite_pkg::*;

  localparam int MaxCycles  = 8000;  // About 400 accesses at up to 20 cycles each
  localparam int L2PoolSize = 32;
  localparam addr_t UnmappedAddrs [5] = '{
    32'h0000_1000, 32'h8000_1000, 32'hA000_0100, 32'h4001_0000, 32'hFFFF_FFFC
  };

  logic       clk_i = 1'b0;
  logic       reset_i;
  addr_t      s_awaddr_i;
  logic       s_awvalid_i;
  logic       s_awready_o;
  data_t      s_wdata_i;
  strb_t      s_wstrb_i;
  logic       s_wvalid_i;
  logic       s_wready_o;
  axi_resp_e  s_bresp_o;
  logic       s_bvalid_o;
  logic       s_bready_i;
  addr_t      s_araddr_i;
  logic       s_arvalid_i;
  logic       s_arready_o;
  data_t      s_rdata_o;
  axi_resp_e  s_rresp_o;
  logic       s_rvalid_o;
  logic       s_rready_i;
  logic       eoc_valid_o;
  core_mask_t wake_up_o;
  logic       busy_o;

  data_t      l2_model [1024];  // Flat word view of the L2 indexed by address bits 11:2
  data_t      eoc_model;
  addr_t      l2_pool [L2PoolSize];
  string      test_name;
  logic       hold_ready;      // Keep bready and rready at 1 for the whole access
  int         hold_override;   // Fixed back-pressure length or -1 for random
  int         cycle_count = 0;
  int         last_wake_cycles;
  core_mask_t last_wake;

  mempool_lite_system i_mempool_lite_system (
    .clk_i      (clk_i      ),
    .reset_i    (reset_i    ),
    .s_awaddr_i (s_awaddr_i ),
    .s_awvalid_i(s_awvalid_i),
    .s_awready_o(s_awready_o),
    .s_wdata_i  (s_wdata_i  ),
    .s_wstrb_i  (s_wstrb_i  ),
    .s_wvalid_i (s_wvalid_i ),
    .s_wready_o (s_wready_o ),
    .s_bresp_o  (s_bresp_o  ),
    .s_bvalid_o (s_bvalid_o ),
    .s_bready_i (s_bready_i ),
    .s_araddr_i (s_araddr_i ),
    .s_arvalid_i(s_arvalid_i),
    .s_arready_o(s_arready_o),
    .s_rdata_o  (s_rdata_o  ),
    .s_rresp_o  (s_rresp_o  ),
    .s_rvalid_o (s_rvalid_o ),
    .s_rready_i (s_rready_i ),
    .eoc_valid_o(eoc_valid_o),
    .wake_up_o  (wake_up_o  ),
    .busy_o     (busy_o     )
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("CHECKS FAILED");
      $fatal(1, "Cycle limit reached");
    end
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      stop_on_error($sformatf("** Error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
    if (exp !== act) begin
      stop_on_error($sformatf("** Error: %s expected %s actual %s (%b)",
                              name, exp.name(), act.name(), act));
    end
  endtask

  task automatic check_mask(input string name, input core_mask_t exp, input core_mask_t act);
    if (exp !== act) begin
      stop_on_error($sformatf("** Error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  // Expected data and response of one access and the model update of a write
  function automatic data_t ref_access(input logic we, input addr_t addr, input data_t wdata,
                                       input strb_t strb, output axi_resp_e resp);
    data_t rd;
    rd   = '0;
    resp = RespOkay;
    if (addr >= L2BaseAddr && addr < L2BaseAddr + 32'h1000) begin
      if (we) begin
        for (int i = 0; i < 4; i++) begin
          if (strb[i]) l2_model[addr[11:2]][8*i +: 8] = wdata[8*i +: 8];
        end
      end else begin
        rd = l2_model[addr[11:2]];
      end
    end else if (addr >= BootromBaseAddr && addr < BootromBaseAddr + 32'h100) begin
      if (we) resp = RespSlvErr;  // ROM has no write path
      else rd = BootImage[addr[7:2]];
    end else if (addr >= CtrlBaseAddr && addr < CtrlBaseAddr + 32'h1_0000) begin
      case (addr[3:2])
        2'd0: begin
          if (we) begin
            for (int i = 0; i < 4; i++) begin
              if (strb[i]) eoc_model[8*i +: 8] = wdata[8*i +: 8];
            end
          end else begin
            rd = eoc_model;
          end
        end
        2'd1: rd = '0;             // Wake-up reads as 0
        2'd2: rd = 32'd8;          // Number of cores
        default: rd = 32'd4096;    // L2 size in bytes
      endcase
    end else begin
      resp = RespSlvErr;
    end
    return rd;
  endfunction

  // Returns on the falling edge after the handshake edge
  task automatic wait_accept(input logic is_write);
    #1;
    while (!(is_write ? (s_awready_o && s_wready_o) : s_arready_o)) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
  endtask

  task automatic finish_response(input logic is_write, output axi_resp_e resp,
                                 output data_t rdata);
    int lat;
    int hold;
    lat              = 0;
    last_wake_cycles = 0;
    last_wake        = '0;
    while (!(is_write ? s_bvalid_o : s_rvalid_o)) begin
      if (!busy_o) stop_on_error("busy_o is low between handshake and response");
      if (wake_up_o != '0) begin
        last_wake_cycles++;
        last_wake = wake_up_o;
      end
      @(negedge clk_i);
      lat++;
    end
    check_data({test_name, " response latency"}, 32'd2, data_t'(lat));
    resp  = is_write ? s_bresp_o : s_rresp_o;
    rdata = s_rdata_o;
    if (!hold_ready) begin
      hold = (hold_override >= 0) ? hold_override : int'($urandom_range(0, 4));
      repeat (hold) begin
        @(negedge clk_i);
        if (s_awready_o || s_wready_o || s_arready_o) begin
          stop_on_error("A ready output rose while a response was held");
        end
        if (!(is_write ? s_bvalid_o : s_rvalid_o)) begin
          stop_on_error("Response valid dropped before the host took it");
        end
        check_resp({test_name, " held resp"}, resp, is_write ? s_bresp_o : s_rresp_o);
        check_data({test_name, " held data"}, rdata, s_rdata_o);
        check_mask({test_name, " wake after pulse"}, '0, wake_up_o);
      end
      if (is_write) s_bready_i = 1'b1;
      else s_rready_i = 1'b1;
    end
    @(negedge clk_i);
    if (!hold_ready) begin
      s_bready_i = 1'b0;
      s_rready_i = 1'b0;
    end
  endtask

  task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
                           output axi_resp_e resp);
    data_t ignored_rdata;
    @(negedge clk_i);
    s_awaddr_i  = addr;
    s_wdata_i   = data;
    s_wstrb_i   = strb;
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
    wait_accept(1'b1);
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    finish_response(1'b1, resp, ignored_rdata);
  endtask

  task automatic axi_read(input addr_t addr, output axi_resp_e resp, output data_t rdata);
    @(negedge clk_i);
    s_araddr_i  = addr;
    s_arvalid_i = 1'b1;
    wait_accept(1'b0);
    s_arvalid_i = 1'b0;
    finish_response(1'b0, resp, rdata);
  endtask

  task automatic write_and_check(input addr_t addr, input data_t data, input strb_t strb);
    axi_resp_e exp_resp;
    axi_resp_e resp;
    void'(ref_access(1'b1, addr, data, strb, exp_resp));
    axi_write(addr, data, strb, resp);
    check_resp($sformatf("%s bresp @%h", test_name, addr), exp_resp, resp);
  endtask

  task automatic read_and_check(input addr_t addr);
    axi_resp_e exp_resp;
    axi_resp_e resp;
    data_t     exp_rdata;
    data_t     rdata;
    exp_rdata = ref_access(1'b0, addr, '0, '0, exp_resp);
    axi_read(addr, resp, rdata);
    check_resp($sformatf("%s rresp @%h", test_name, addr), exp_resp, resp);
    check_data($sformatf("%s rdata @%h", test_name, addr), exp_rdata, rdata);
  endtask

  // AW, W and AR raised together with AR up through the write response
  task automatic write_read_same_cycle(input addr_t addr, input data_t data);
    axi_resp_e exp_resp;
    axi_resp_e resp;
    data_t     exp_rdata;
    data_t     rdata;
    void'(ref_access(1'b1, addr, data, 4'hF, exp_resp));
    @(negedge clk_i);
    s_awaddr_i  = addr;
    s_wdata_i   = data;
    s_wstrb_i   = 4'hF;
    s_araddr_i  = addr;
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
    s_arvalid_i = 1'b1;
    wait_accept(1'b1);
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    finish_response(1'b1, resp, rdata);
    check_resp({test_name, " bresp"}, exp_resp, resp);
    exp_rdata = ref_access(1'b0, addr, '0, '0, exp_resp);
    wait_accept(1'b0);
    s_arvalid_i = 1'b0;
    finish_response(1'b0, resp, rdata);
    check_resp({test_name, " rresp"}, exp_resp, resp);
    check_data({test_name, " rdata"}, exp_rdata, rdata);
  endtask

  initial begin
    int unsigned row;
    void'($urandom(32'ha142_dd3b));
    reset_i       = 1'b1;
    s_awaddr_i    = '0;
    s_awvalid_i   = 1'b0;
    s_wdata_i     = '0;
    s_wstrb_i     = '0;
    s_wvalid_i    = 1'b0;
    s_bready_i    = 1'b0;
    s_araddr_i    = '0;
    s_arvalid_i   = 1'b0;
    s_rready_i    = 1'b0;
    hold_ready    = 1'b0;
    hold_override = -1;
    eoc_model     = '0;
    foreach (l2_model[i]) l2_model[i] = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    test_name = "reset";
    if (s_awready_o || s_wready_o || s_arready_o || s_bvalid_o || s_rvalid_o ||
        eoc_valid_o || busy_o) begin
      stop_on_error("An output is not 0 after reset");
    end
    check_mask(test_name, '0, wake_up_o);

    // Pool words cover every bank and start fully written
    test_name = "l2 init";
    for (int i = 0; i < L2PoolSize; i++) begin
      row        = $urandom_range(0, 255);
      l2_pool[i] = L2BaseAddr + addr_t'((row * 4 + (i % 4)) * 4);
      write_and_check(l2_pool[i], $urandom(), 4'hF);
    end
    test_name = "l2 random write";
    for (int i = 0; i < 200; i++) begin
      write_and_check(l2_pool[$urandom_range(0, L2PoolSize - 1)], $urandom(),
                      strb_t'($urandom_range(0, 15)));
    end
    test_name = "l2 read back";
    for (int i = 0; i < L2PoolSize; i++) read_and_check(l2_pool[i]);

    test_name = "boot rom read";
    for (int i = 0; i < 64; i++) read_and_check(BootromBaseAddr + addr_t'(i * 4));
    test_name = "boot rom write";
    write_and_check(BootromBaseAddr + 32'h14, 32'hFFFF_FFFF, 4'hF);
    read_and_check(BootromBaseAddr + 32'h14);

    test_name = "unmapped";
    foreach (UnmappedAddrs[i]) begin
      write_and_check(UnmappedAddrs[i], 32'h1234_5678, 4'hF);
      read_and_check(UnmappedAddrs[i]);
    end

    test_name = "eoc set";
    write_and_check(CtrlBaseAddr, 32'h0000_0001, 4'hF);
    check_data({test_name, " eoc_valid"}, 32'd1, data_t'(eoc_valid_o));
    read_and_check(CtrlBaseAddr);
    test_name = "eoc byte strobe";
    write_and_check(CtrlBaseAddr, 32'h00A5_0000, 4'b0100);
    read_and_check(CtrlBaseAddr);
    test_name = "eoc clear";
    write_and_check(CtrlBaseAddr, 32'h0000_0000, 4'hF);
    check_data({test_name, " eoc_valid"}, 32'd0, data_t'(eoc_valid_o));
    check_data({test_name, " no wake pulse"}, 32'd0, data_t'(last_wake_cycles));
    test_name     = "wake up";
    hold_override = 2;  // Wake-up must stay 0 while bvalid is held
    write_and_check(CtrlBaseAddr + 32'h4, 32'h0000_005A, 4'hF);
    hold_override = -1;
    check_mask(test_name, 8'h5A, last_wake);
    check_data({test_name, " pulse cycles"}, 32'd1, data_t'(last_wake_cycles));
    read_and_check(CtrlBaseAddr + 32'h4);
    test_name = "info regs";
    read_and_check(CtrlBaseAddr + 32'h8);
    read_and_check(CtrlBaseAddr + 32'hC);
    write_and_check(CtrlBaseAddr + 32'h8, 32'hFFFF_FFFF, 4'hF);  // Ignored but still OKAY
    read_and_check(CtrlBaseAddr + 32'h8);

    test_name  = "latency";
    hold_ready = 1'b1;
    s_bready_i = 1'b1;
    s_rready_i = 1'b1;
    for (int i = 0; i < 8; i++) begin
      write_and_check(l2_pool[i], $urandom(), 4'hF);
      read_and_check(l2_pool[i]);
    end
    read_and_check(BootromBaseAddr + 32'h10);
    hold_ready = 1'b0;
    s_bready_i = 1'b0;
    s_rready_i = 1'b0;

    test_name     = "write before read";
    hold_override = 4;
    write_read_same_cycle(l2_pool[3], 32'h1357_9BDF);
    write_read_same_cycle(CtrlBaseAddr, 32'h0000_0003);
    hold_override = -1;

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule : tb_mempool_lite_system

//--- sources.f
src/mempool_lite_pkg.sv
src/axi_lite_frontend.sv
src/l2_banks.sv
src/bootrom.sv
src/ctrl_registers.sv
src/mempool_lite_system.sv
testbench/tb_mempool_lite_system.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
TOP=tb_mempool_lite_system

verilator --binary --timing \
  --top-module "$TOP" \
  --Mdir "$BUILD_DIR" -o "$TOP" \
  -f sources.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi
echo "Simulation finished without failures"
exit 0
